/* hdl/plicPkg.sv */
// shared constants for the interrupt controller, referenced by scoped name from every RTL file
package plicPkg;

  ////////////////////////////////////////
  // sizes
  ////////////////////////////////////////

  // sources are numbered 1..numSrc, id 0 means none
  localparam int numSrc = 8;
  // priority and threshold width
  localparam int prioW = 3;
  // wide enough for ids 0..numSrc
  localparam int idW = 4;
  // AHB-Lite data bus
  localparam int dataW = 32;
  // decoded part of HADDR
  localparam int addrW = 24;

  ////////////////////////////////////////
  // register map, byte offsets
  ////////////////////////////////////////

  // source n sits at priorityBase + 4*n
  localparam logic [addrW-1:0] priorityBase = 24'h000000;
  // read only, bit n is source n
  localparam logic [addrW-1:0] pendingAddr = 24'h001000;
  // bit n is source n
  localparam logic [addrW-1:0] enableAddr = 24'h002000;
  localparam logic [addrW-1:0] thresholdAddr = 24'h200000;
  // read claims, write completes
  localparam logic [addrW-1:0] claimAddr = 24'h200004;

  // HTRANS code for no transfer
  localparam logic [1:0] htransIdle = 2'b00;

endpackage

/* hdl/ahbPlicPort.sv */
// AHB-Lite register port of the interrupt controller, holds priority, enable and threshold
`timescale 1ns/1ps

module ahbPlicPort (
  input  logic                                           HCLK,
  input  logic                                           HRESETn,
  input  logic                                           HSEL,
  input  logic [plicPkg::addrW-1:0]                      HADDR,
  input  logic                                           HWRITE,
  input  logic [1:0]                                     HTRANS,
  input  logic                                           HREADY,
  input  logic [plicPkg::dataW-1:0]                      HWDATA,
  output logic [plicPkg::dataW-1:0]                      HRDATA,
  output logic                                           HREADYOUT,
  output logic                                           HRESP,
  input  logic [plicPkg::numSrc-1:0]                     pending,
  input  logic [plicPkg::idW-1:0]                        claimId,
  output logic [plicPkg::numSrc-1:0][plicPkg::prioW-1:0] srcPriority,
  output logic [plicPkg::numSrc-1:0]                     enable,
  output logic [plicPkg::prioW-1:0]                      threshold,
  output logic                                           claimStrobe,
  output logic                                           completeStrobe,
  output logic [plicPkg::idW-1:0]                        completeId
);

  logic                      accept;
  logic                      rdAccept;
  logic                      wrPhase;
  logic [plicPkg::addrW-1:0] addrQ;
  logic [plicPkg::dataW-1:0] rdData;

  // byte address of the priority register of source src
  function automatic logic [plicPkg::addrW-1:0] prioAddr(input int src);
    prioAddr = plicPkg::priorityBase + {src[plicPkg::addrW-3:0], 2'b00};
  endfunction

  ////////////////////////////////////////
  // address phase
  ////////////////////////////////////////

  // a transfer starts when selected, bus ready and not idle
  assign accept = HSEL & HREADY & (HTRANS != plicPkg::htransIdle);
  assign rdAccept = accept & ~HWRITE;

  // zero wait states, always OKAY
  assign HREADYOUT = 1'b1;
  assign HRESP = 1'b0;

  // write data phase follows an accepted write
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wrPhase <= 1'b0;
    end else begin
      wrPhase <= accept & HWRITE;
    end
  end

  // address kept for the data phase
  always_ff @(posedge HCLK) begin
    if (accept) begin
      addrQ <= HADDR;
    end
  end

  ////////////////////////////////////////
  // register writes, end of data phase
  ////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      srcPriority <= '0;
      enable <= '0;
      threshold <= '0;
    end else if (wrPhase) begin
      // no slot above numSrc, upper data bits dropped
      for (int src = 1; src <= plicPkg::numSrc; src++) begin
        if (addrQ == prioAddr(src)) begin
          srcPriority[src-1] <= HWDATA[plicPkg::prioW-1:0];
        end
      end
      // bit 0 of the bus is the nonexistent source 0
      if (addrQ == plicPkg::enableAddr) begin
        enable <= HWDATA[plicPkg::numSrc:1];
      end
      if (addrQ == plicPkg::thresholdAddr) begin
        threshold <= HWDATA[plicPkg::prioW-1:0];
      end
    end
  end

  // completion is seen by the gateway during the data phase
  assign completeStrobe = wrPhase & (addrQ == plicPkg::claimAddr);
  assign completeId = HWDATA[plicPkg::idW-1:0];

  ////////////////////////////////////////
  // read path
  ////////////////////////////////////////

  // unmapped offsets fall through as zero
  always_comb begin
    rdData = '0;
    for (int src = 1; src <= plicPkg::numSrc; src++) begin
      if (HADDR == prioAddr(src)) begin
        rdData[plicPkg::prioW-1:0] = srcPriority[src-1];
      end
    end
    if (HADDR == plicPkg::pendingAddr) begin
      rdData[plicPkg::numSrc:1] = pending;
    end
    if (HADDR == plicPkg::enableAddr) begin
      rdData[plicPkg::numSrc:1] = enable;
    end
    if (HADDR == plicPkg::thresholdAddr) begin
      rdData[plicPkg::prioW-1:0] = threshold;
    end
    if (HADDR == plicPkg::claimAddr) begin
      rdData[plicPkg::idW-1:0] = claimId;
    end
  end

  // read data and claim strobe both live for the data phase
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      HRDATA <= '0;
      claimStrobe <= 1'b0;
    end else begin
      HRDATA <= rdAccept ? rdData : '0;
      claimStrobe <= rdAccept & (HADDR == plicPkg::claimAddr);
    end
  end

endmodule

/* hdl/plicGateway.sv */
// per-source gateways of the interrupt controller, keep pending and in-progress bits
`timescale 1ns/1ps

module plicGateway (
  input  logic                       HCLK,
  input  logic                       HRESETn,
  input  logic [plicPkg::numSrc-1:0] irq,
  input  logic                       claimStrobe,
  input  logic                       completeStrobe,
  input  logic [plicPkg::idW-1:0]    claimId,
  input  logic [plicPkg::idW-1:0]    completeId,
  output logic [plicPkg::numSrc-1:0] pending
);

  logic [plicPkg::numSrc-1:0] inProgress;
  logic [plicPkg::numSrc-1:0] claimMask;
  logic [plicPkg::numSrc-1:0] completeMask;
  logic [plicPkg::idW-1:0]    claimIdQ;

  // one-hot source mask, bit 0 is source 1, id 0 or out of range gives none
  function automatic logic [plicPkg::numSrc-1:0] idToMask(input logic [plicPkg::idW-1:0] id);
    logic [plicPkg::numSrc-1:0] mask;
    mask = '0;
    for (int src = 0; src < plicPkg::numSrc; src++) begin
      if (id == src[plicPkg::idW-1:0] + 1'b1) begin
        mask[src] = 1'b1;
      end
    end
    return mask;
  endfunction

  ////////////////////////////////////////
  // claim and completion decode
  ////////////////////////////////////////

  // id as it was on the claim read's address edge
  // so the cleared source is the one handed to software
  always_ff @(posedge HCLK) begin
    claimIdQ <= claimId;
  end

  assign claimMask = claimStrobe ? idToMask(claimIdQ) : '0;
  assign completeMask = completeStrobe ? idToMask(completeId) : '0;

  ////////////////////////////////////////
  // gateway state
  ////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      pending <= '0;
      inProgress <= '0;
    end else begin
      // level sets pending unless the handler is still running
      // claim wins over a set in the same cycle
      pending <= (pending | (irq & ~inProgress)) & ~claimMask;
      // completing an idle source leaves the bit at 0
      inProgress <= (inProgress | claimMask) & ~completeMask;
    end
  end

endmodule

/* hdl/plicArbiter.sv */
// combinational arbiter of the interrupt controller, forms the claim id and the interrupt line
`timescale 1ns/1ps

module plicArbiter (
  input  logic [plicPkg::numSrc-1:0][plicPkg::prioW-1:0] srcPriority,
  input  logic [plicPkg::numSrc-1:0]                     enable,
  input  logic [plicPkg::numSrc-1:0]                     pending,
  input  logic [plicPkg::prioW-1:0]                      threshold,
  output logic [plicPkg::idW-1:0]                        claimId,
  output logic                                           extIrq
);

  // one row per priority level, level 0 never competes
  logic [2**plicPkg::prioW-1:1][plicPkg::numSrc-1:0] lvlHit;
  logic [2**plicPkg::prioW-1:1]                      lvlAny;
  logic [plicPkg::prioW-1:0]                         topLvl;
  logic [plicPkg::numSrc-1:0]                        topHit;

  ////////////////////////////////////////
  // grouping by level
  ////////////////////////////////////////

  // enabled pending sources sorted into their priority row
  always_comb begin
    for (int lvl = 1; lvl < 2**plicPkg::prioW; lvl++) begin
      for (int src = 0; src < plicPkg::numSrc; src++) begin
        lvlHit[lvl][src] = enable[src] & pending[src]
                         & (srcPriority[src] == lvl[plicPkg::prioW-1:0]);
      end
      lvlAny[lvl] = |lvlHit[lvl];
    end
  end

  ////////////////////////////////////////
  // highest level, then lowest id
  ////////////////////////////////////////

  // scanning upward, the last non-empty row is the top one
  always_comb begin
    topLvl = '0;
    topHit = '0;
    for (int lvl = 1; lvl < 2**plicPkg::prioW; lvl++) begin
      if (lvlAny[lvl]) begin
        topLvl = lvl[plicPkg::prioW-1:0];
        topHit = lvlHit[lvl];
      end
    end
  end

  // scanning downward, the last hit is the lowest id
  always_comb begin
    claimId = '0;
    for (int src = plicPkg::numSrc - 1; src >= 0; src--) begin
      if (topHit[src]) begin
        claimId = src[plicPkg::idW-1:0] + 1'b1;
      end
    end
  end

  // topLvl is 0 with nothing pending, which never beats a threshold
  assign extIrq = topLvl > threshold;

endmodule

/* hdl/plicTop.sv */
// top level of the interrupt controller, joins the AHB port, the gateways and the arbiter
`timescale 1ns/1ps

module plicTop (
  input  logic                       HCLK,
  input  logic                       HRESETn,
  input  logic                       HSEL,
  input  logic [plicPkg::addrW-1:0]  HADDR,
  input  logic                       HWRITE,
  input  logic [1:0]                 HTRANS,
  input  logic                       HREADY,
  input  logic [plicPkg::dataW-1:0]  HWDATA,
  output logic [plicPkg::dataW-1:0]  HRDATA,
  output logic                       HREADYOUT,
  output logic                       HRESP,
  input  logic [plicPkg::numSrc-1:0] irq,
  output logic                       extIrq
);

  ////////////////////////////////////////
  // internal nets
  ////////////////////////////////////////

  // register state towards the arbiter
  logic [plicPkg::numSrc-1:0][plicPkg::prioW-1:0] srcPriority;
  logic [plicPkg::numSrc-1:0]                     enable;
  logic [plicPkg::prioW-1:0]                      threshold;
  // claim and completion towards the gateways
  logic                                           claimStrobe;
  logic                                           completeStrobe;
  logic [plicPkg::idW-1:0]                        completeId;
  // gateway and arbiter results
  logic [plicPkg::numSrc-1:0]                     pending;
  logic [plicPkg::idW-1:0]                        claimId;

  // bus side
  ahbPlicPort port_i (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .HSEL           (HSEL),
    .HADDR          (HADDR),
    .HWRITE         (HWRITE),
    .HTRANS         (HTRANS),
    .HREADY         (HREADY),
    .HWDATA         (HWDATA),
    .HRDATA         (HRDATA),
    .HREADYOUT      (HREADYOUT),
    .HRESP          (HRESP),
    .pending        (pending),
    .claimId        (claimId),
    .srcPriority    (srcPriority),
    .enable         (enable),
    .threshold      (threshold),
    .claimStrobe    (claimStrobe),
    .completeStrobe (completeStrobe),
    .completeId     (completeId)
  );

  // pending and in-progress state
  plicGateway gw_i (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .irq            (irq),
    .claimStrobe    (claimStrobe),
    .completeStrobe (completeStrobe),
    .claimId        (claimId),
    .completeId     (completeId),
    .pending        (pending)
  );

  // winner selection and interrupt line
  plicArbiter arb_i (
    .srcPriority (srcPriority),
    .enable      (enable),
    .pending     (pending),
    .threshold   (threshold),
    .claimId     (claimId),
    .extIrq      (extIrq)
  );

endmodule

/* bench/plicTb_chk.sv */
// bus response and interrupt line assertions, bound into the interrupt controller top level
`timescale 1ns/1ps

module plicChk (
  input logic                    HCLK,
  input logic                    HRESETn,
  input logic                    HREADYOUT,
  input logic                    HRESP,
  input logic                    extIrq,
  input logic                    claimStrobe,
  input logic [plicPkg::idW-1:0] claimId
);

  // zero wait states and OKAY response while out of reset
  busOkay: assert property (@(posedge HCLK) disable iff (!HRESETn) HREADYOUT && !HRESP)
    else $error("bus response left the zero-wait OKAY state");

  // a raised line always has a source to hand out
  irqHasId: assert property (@(posedge HCLK) disable iff (!HRESETn) extIrq |-> claimId != '0)
    else $error("extIrq high while claimId is zero");

  // claim strobe is a single-cycle pulse
  claimPulse: assert property (@(posedge HCLK) disable iff (!HRESETn) claimStrobe |=> !claimStrobe)
    else $error("claimStrobe held for two cycles");

endmodule

bind plicTop plicChk chk_i (
  .HCLK        (HCLK),
  .HRESETn     (HRESETn),
  .HREADYOUT   (HREADYOUT),
  .HRESP       (HRESP),
  .extIrq      (extIrq),
  .claimStrobe (claimStrobe),
  .claimId     (claimId)
);

/* bench/plicTb.sv */
// testbench for the interrupt controller, runs the operations listed in the cases file
`timescale 1ns/1ps

module plicTb;

  logic                       HCLK;
  logic                       HRESETn;
  logic                       HSEL;
  logic [plicPkg::addrW-1:0]  HADDR;
  logic                       HWRITE;
  logic [1:0]                 HTRANS;
  logic                       HREADY;
  logic [plicPkg::dataW-1:0]  HWDATA;
  logic [plicPkg::dataW-1:0]  HRDATA;
  logic                       HREADYOUT;
  logic                       HRESP;
  logic [plicPkg::numSrc-1:0] irq;
  logic                       extIrq;

  // four words per operation as opcode, address or irq mask, data and expected
  logic [31:0] caseMem [0:255];
  int          numCases = 0;

  plicTop dut_i (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HWRITE    (HWRITE),
    .HTRANS    (HTRANS),
    .HREADY    (HREADY),
    .HWDATA    (HWDATA),
    .HRDATA    (HRDATA),
    .HREADYOUT (HREADYOUT),
    .HRESP     (HRESP),
    .irq       (irq),
    .extIrq    (extIrq)
  );

  // 10 ns clock
  initial begin
    HCLK = 1'b0;
    forever #5 HCLK = ~HCLK;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("Done: errors found");
      $fatal(1, "check on %s failed", name);
    end
  endtask

  // address phase then data phase, returning after the register update edge
  task automatic busWrite(input logic [plicPkg::addrW-1:0] addr, input logic [31:0] data);
    @(posedge HCLK);
    HSEL <= 1'b1;
    HADDR <= addr;
    HWRITE <= 1'b1;
    // NONSEQ
    HTRANS <= 2'b10;
    @(posedge HCLK);
    HSEL <= 1'b0;
    HWRITE <= 1'b0;
    HTRANS <= plicPkg::htransIdle;
    HWDATA <= data;
    @(posedge HCLK);
  endtask

  // read data is sampled mid data phase
  task automatic busRead(input logic [plicPkg::addrW-1:0] addr, output logic [31:0] data);
    @(posedge HCLK);
    HSEL <= 1'b1;
    HADDR <= addr;
    HWRITE <= 1'b0;
    HTRANS <= 2'b10;
    @(posedge HCLK);
    HSEL <= 1'b0;
    HTRANS <= plicPkg::htransIdle;
    @(negedge HCLK);
    data = HRDATA;
  endtask

  task automatic driveIrq(input logic [plicPkg::numSrc-1:0] mask);
    @(posedge HCLK);
    irq <= mask;
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    int          found;
    logic [7:0]  base;
    logic [31:0] opField;
    logic [31:0] argField;
    logic [31:0] dataField;
    logic [31:0] expField;
    logic [31:0] rdVal;
    void'($urandom(32'hebd7));
    HRESETn = 1'b0;
    HSEL = 1'b0;
    HADDR = '0;
    HWRITE = 1'b0;
    HTRANS = plicPkg::htransIdle;
    HREADY = 1'b1;
    HWDATA = '0;
    irq = '0;
    $readmemh("bench/plicCases.mem", caseMem);
    // list ends at the first zero opcode
    found = 0;
    while (found < 64 && caseMem[8'(found * 4)] != 32'h0) begin
      found++;
    end
    if (found == 0) begin
      $display("no operations found in the cases file");
      $display("Done: errors found");
      $fatal(1, "empty case list");
    end
    numCases = found;
    repeat (3) @(posedge HCLK);
    HRESETn <= 1'b1;
    for (int i = 0; i < numCases; i++) begin
      base = 8'(i * 4);
      opField = caseMem[base];
      argField = caseMem[base + 8'd1];
      dataField = caseMem[base + 8'd2];
      expField = caseMem[base + 8'd3];
      case (opField)
        32'd1: busWrite(argField[plicPkg::addrW-1:0], dataField);
        32'd2: begin
          busRead(argField[plicPkg::addrW-1:0], rdVal);
          checkValue("HRDATA", rdVal, expField);
        end
        32'd3: driveIrq(argField[plicPkg::numSrc-1:0]);
        32'd4: begin
          // one cycle for pending or register state to settle
          @(posedge HCLK);
          @(negedge HCLK);
          checkValue("extIrq", {31'b0, extIrq}, expField);
        end
        default: begin
          $display("unknown opcode %0h on case line %0d", opField, i);
          $display("Done: errors found");
          $fatal(1, "bad case file");
        end
      endcase
      // random bus idle between operations
      repeat ($urandom % 3) @(posedge HCLK);
    end
    $display("Done: no errors");
    $finish;
  end

  // 40 cycles per case line plus reset margin
  initial begin
    wait (numCases != 0);
    #(numCases * 400 + 100);
    $display("timeout, the case list did not complete in time");
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

endmodule

/* plicSubsys.f */
hdl/plicPkg.sv
hdl/ahbPlicPort.sv
hdl/plicGateway.sv
hdl/plicArbiter.sv
hdl/plicTop.sv
bench/plicTb_chk.sv
bench/plicTb.sv

/* build.sh */
#!/bin/sh
# compile the interrupt controller bench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module plicTb \
  -f plicSubsys.f --Mdir obj_dir -o plicSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
  echo "verilator build failed with status $buildStatus"
  exit $buildStatus
fi

./obj_dir/plicSim
simStatus=$?
if [ $simStatus -ne 0 ]; then
  echo "simulation failed with status $simStatus"
  exit $simStatus
fi

echo "simulation finished cleanly"
exit 0

/* bench/plicCases.mem */
// op addr data expect, all hex; op 1 write, 2 read HRDATA, 3 irq mask in addr, 4 check extIrq
// op 0 ends the list
// reset state
2 000004 0 0
2 001000 0 0
2 002000 0 0
2 200000 0 0
2 200004 0 0
4 0 0 0
// read back masked to width, unmapped reads 0
1 000004 fffffffd 0
2 000004 0 5
1 000020 00000003 0
2 000020 0 3
1 000024 00000007 0
2 000024 0 0
1 002000 ffffffff 0
2 002000 0 1fe
1 200000 0000000e 0
2 200000 0 6
2 003000 0 0
// priorities 1:5 2:5 3:7 4:0 5:6 8:3, enable 1 to 4 and 8, threshold 0
1 000008 5 0
1 00000c 7 0
1 000014 6 0
1 002000 11e 0
1 200000 0 0
// disabled or zero priority sources never win
3 10 0 0
4 0 0 0
2 001000 0 20
2 200004 0 0
3 18 0 0
2 001000 0 30
2 200004 0 0
4 0 0 0
// threshold gates the line
3 19 0 0
4 0 0 1
2 001000 0 32
1 200000 5 0
4 0 0 0
1 200000 4 0
4 0 0 1
// claim, completion, completion of an idle id
2 200004 0 1
2 001000 0 30
4 0 0 0
1 200004 1 0
2 001000 0 32
1 200004 2 0
2 001000 0 32
// successive claims in priority order, then none
3 9f 0 0
1 200000 0 0
2 001000 0 13e
2 200004 0 3
2 200004 0 1
2 200004 0 2
2 200004 0 8
2 200004 0 0
4 0 0 0
2 001000 0 30
1 200004 3 0
2 001000 0 38
2 200004 0 3
0 0 0 0
